// File: laa.f
src/laa_isa_pkg.sv
src/laa_bus_pkg.sv
src/laa_decoder.sv
src/laa_regfile.sv
src/laa_mac_engine.sv
src/laa_top.sv
verification/laa_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module laa_tb -f laa.f -o laa_sim \
    && ./obj_dir/laa_sim | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verification/laa_tb.sv
`timescale 1ns/1ps

module laa_tb;
    import laa_bus_pkg::*;

    localparam int VEC_LEN      = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RAND     = 40;  // Write then read pairs
    localparam int NUM_BAD      = 20;  // Illegal words
    // Rough run length with three read sweeps and two MAC runs
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 * 32 + 2 * NUM_RAND + NUM_BAD
                                  + 2 * (3 * VEC_LEN + 4) + 16;
    localparam int MAX_CYCLES   = 8 * TEST_CYCLES;  // Ample margin

    localparam logic [6:0]  MAJOR   = 7'b0001011;  // custom-0
    localparam logic [4:0]  F_READ  = 5'b00001;
    localparam logic [4:0]  F_WRITE = 5'b00010;
    localparam logic [4:0]  F_EXEC  = 5'b00011;
    localparam logic [31:0] NOP     = 32'h0000_0000;  // Foreign major opcode is ignored

    localparam int K_NONE  = 0;
    localparam int K_READ  = 1;
    localparam int K_WRITE = 2;
    localparam int K_EXEC  = 3;

    // One expected core write back
    typedef struct packed {
        int          due;   // Cycle it must show up in
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_resp_t;

    logic        bus;
    logic        reset;
    logic [31:0] ins;
    logic [31:0] rs1_data;
    logic [4:0]  rs1_addr;
    laa_resp_t   resp;
    logic        busy;

    logic [31:0] model [32];   // Reference register file
    exp_resp_t   resp_q [$];   // Pending READ responses
    int          cyc          = 0;
    int          exec_cyc     = -1000;  // Cycle of the last accepted EXEC
    bit          checking     = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;

    laa_top #(
        .VEC_LEN (VEC_LEN)
    ) laa_top_inst (
        .bus      (bus),
        .reset    (reset),
        .ins      (ins),
        .rs1_data (rs1_data),
        .rs1_addr (rs1_addr),
        .resp     (resp),
        .busy     (busy)
    );

    ////////////////////////////////////////////////////////////
    // Clock, cycle count, watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        bus = 1'b0;
        forever #50 bus = ~bus;  // 100 ns period
    end

    always @(posedge bus) cyc <= cyc + 1;

    initial begin : watchdog
        while (cyc < MAX_CYCLES) @(posedge bus);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_write(input logic [4:0] core_reg,
                                              input logic [4:0] laa_reg);
        return {core_reg, laa_reg, 10'b0, F_WRITE, MAJOR};
    endfunction

    function automatic logic [31:0] enc_read(input logic [4:0] laa_reg,
                                             input logic [4:0] core_reg);
        return {laa_reg, core_reg, 10'b0, F_READ, MAJOR};  // Fields swapped
    endfunction

    function automatic logic [31:0] enc_exec();
        return {20'b0, F_EXEC, MAJOR};
    endfunction

    function automatic int classify(input logic [31:0] word);
        int kind;
        kind = K_NONE;
        if (word[6:0] == MAJOR) begin
            case (word[11:7])
                F_READ:  kind = K_READ;
                F_WRITE: kind = K_WRITE;
                F_EXEC:  kind = K_EXEC;
                default: kind = K_NONE;  // Unknown function
            endcase
        end
        return kind;
    endfunction

    // Busy from the cycle after EXEC for VEC_LEN cycles
    function automatic logic busy_window(input int c);
        return (c > exec_cyc) && (c <= exec_cyc + VEC_LEN);
    endfunction

    function automatic logic [31:0] ref_dot();
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            sum = sum + model[i] * model[VEC_LEN + i];  // Low word of the unsigned product
        end
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    // Called 1 ns after an edge and returns 1 ns after the next one
    task automatic present_word(input logic [31:0] word, input logic [31:0] rs1);
        int        kind;
        logic      taken;
        exp_resp_t e;
        kind     = classify(word);
        taken    = (kind != K_NONE) && !busy_window(cyc);
        ins      = word;
        rs1_data = rs1;
        if (taken) begin
            case (kind)
                K_WRITE: model[word[26:22]] = rs1;
                K_READ: begin
                    e.due  = cyc + 1;             // Registered response
                    e.rd   = word[26:22];
                    e.data = model[word[31:27]];
                    resp_q.push_back(e);
                end
                K_EXEC: begin
                    exec_cyc  = cyc;
                    model[31] = ref_dot();  // Replaces the old result
                end
                default: ;
            endcase
        end
        @(negedge bus);
        if (taken && kind == K_WRITE) begin
            assert (rs1_addr == word[31:27]) else begin
                value_errors++;
                $display("Fail at %0t: rs1_addr %0d, expected %0d",
                         $time, rs1_addr, word[31:27]);
            end
        end
        @(posedge bus);
        #1;
    endtask

    task automatic send_write(input logic [4:0] core_reg, input logic [4:0] laa_reg,
                              input logic [31:0] value);
        present_word(enc_write(core_reg, laa_reg), value);
    endtask

    task automatic send_read(input logic [4:0] laa_reg, input logic [4:0] core_reg);
        present_word(enc_read(laa_reg, core_reg), $urandom);
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 32; r++) begin
            send_read(5'(r), 5'($urandom_range(31, 0)));
        end
    endtask

    // Vector A from r0 up and vector B right after it
    task automatic load_vectors();
        for (int r = 0; r < 2 * VEC_LEN; r++) begin
            send_write(5'($urandom_range(31, 0)), 5'(r), $urandom);
        end
    endtask

    // Legal instruction that must be dropped while busy, kind picked by sel
    function automatic logic [31:0] busy_junk(input int sel);
        logic [31:0] w;
        w = $urandom;
        case (sel % 3)
            0:       w = enc_write(w[31:27], w[26:22]);
            1:       w = enc_read(w[31:27], w[26:22]);
            default: w = enc_exec();
        endcase
        return w;
    endfunction

    task automatic run_exec();
        int busy_cycles;
        busy_cycles = 0;
        present_word(enc_exec(), $urandom);
        while (busy) begin
            busy_cycles++;
            present_word(busy_junk(busy_cycles), $urandom);  // Stall period traffic
        end
        assert (busy_cycles == VEC_LEN) else begin
            value_errors++;
            $display("Fail at %0t: busy lasted %0d cycles, expected %0d",
                     $time, busy_cycles, VEC_LEN);
        end
        send_read(5'd31, 5'($urandom_range(31, 0)));  // Result register
    endtask

    ////////////////////////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////////////////////////

    always @(negedge bus) begin : compare
        exp_resp_t e;
        if (checking) begin
            assert (busy == busy_window(cyc)) else begin
                value_errors++;
                $display("Fail at %0t: busy %0b, expected %0b", $time, busy, busy_window(cyc));
            end
            if (resp_q.size() != 0 && resp_q[0].due == cyc) begin
                e = resp_q.pop_front();
                assert (resp.reg_write) else begin
                    other_errors++;
                    $display("Read response for core r%0d did not arrive at %0t", e.rd, $time);
                end
                if (resp.reg_write) begin
                    assert (resp.rd == e.rd && resp.data == e.data) else begin
                        value_errors++;
                        $display("Fail at %0t: resp r%0d = %h, expected r%0d = %h",
                                 $time, resp.rd, resp.data, e.rd, e.data);
                    end
                end
            end else begin
                assert (!resp.reg_write) else begin
                    other_errors++;
                    $display("Unexpected core register write to r%0d at %0t", resp.rd, $time);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] w;
        void'($urandom(12534));
        reset    = 1'b1;
        ins      = NOP;
        rs1_data = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end

        // Legal traffic under reset must leave no trace
        repeat (RESET_CYCLES - 2) begin
            @(posedge bus);
            #1;
            ins      = enc_write(5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
            rs1_data = $urandom | 32'd1;  // Never zero
        end
        @(posedge bus);
        #1;
        ins = enc_read(5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));  // Last reset edge
        @(posedge bus);
        #1;
        reset = 1'b0;
        ins   = NOP;

        // Reset state
        assert (resp.reg_write == 1'b0 && busy == 1'b0) else begin
            value_errors++;
            $display("Fail at %0t: reg_write %0b busy %0b after reset",
                     $time, resp.reg_write, busy);
        end
        checking = 1'b1;
        read_all_regs();

        // Write then read back
        for (int n = 0; n < NUM_RAND; n++) begin
            w = $urandom;
            send_write(w[4:0], w[9:5], $urandom);
            send_read(w[9:5], w[14:10]);
        end

        // Foreign opcodes and unknown function codes
        for (int n = 0; n < NUM_BAD; n++) begin
            w = $urandom;
            if (n % 2 == 0) begin
                if (w[6:0] == MAJOR) w[0] = ~w[0];
            end else begin
                w[6:0] = MAJOR;
                if (w[11:7] inside {F_READ, F_WRITE, F_EXEC}) w[11:7] = 5'b11111;
            end
            present_word(w, $urandom);
        end
        read_all_regs();

        // Dot product and then a second run on new operands
        load_vectors();
        run_exec();
        read_all_regs();  // Dropped traffic left no trace
        load_vectors();
        run_exec();

        while (resp_q.size() != 0) present_word(NOP, '0);
        present_word(NOP, '0);
        checking = 1'b0;

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src/laa_top.sv
`timescale 1ns/1ps

module laa_top #(
    parameter int VEC_LEN = 4  // Dot product length, 1 to 15
) (
    input  logic                   bus,       // Clock
    input  logic                   reset,
    input  laa_isa_pkg::laa_ins_u  ins,       // custom-0 instruction word
    input  logic [31:0]            rs1_data,  // Core rs1 contents
    output logic [4:0]             rs1_addr,  // Core rs1 select
    output laa_bus_pkg::laa_resp_t resp,      // Core register write back
    output logic                   busy       // Core stalls on this
);
    import laa_bus_pkg::*;

    laa_wr_t     core_wr;  // Decoder to regfile
    laa_wr_t     eng_wr;   // Engine to regfile
    laa_pair_t   pair;
    logic        rd_req;
    logic [4:0]  rd_laa;
    logic [4:0]  rd_core;
    logic        start;
    logic [31:0] data_a;
    logic [31:0] data_b;

    ////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////

    laa_decoder laa_decoder_inst (
        .bus      (bus),
        .reset    (reset),
        .ins      (ins),
        .rs1_data (rs1_data),
        .busy     (busy),
        .rs1_addr (rs1_addr),
        .core_wr  (core_wr),
        .rd_req   (rd_req),
        .rd_laa   (rd_laa),
        .rd_core  (rd_core),
        .start    (start)
    );

    ////////////////////////////////////////////////////////////
    // Accelerator datapath
    ////////////////////////////////////////////////////////////

    laa_regfile laa_regfile_inst (
        .bus     (bus),
        .reset   (reset),
        .core_wr (core_wr),
        .eng_wr  (eng_wr),
        .rd_req  (rd_req),
        .rd_laa  (rd_laa),
        .rd_core (rd_core),
        .pair    (pair),
        .data_a  (data_a),
        .data_b  (data_b),
        .resp    (resp)
    );

    laa_mac_engine #(
        .VEC_LEN (VEC_LEN)
    ) laa_mac_engine_inst (
        .bus    (bus),
        .reset  (reset),
        .start  (start),
        .data_a (data_a),
        .data_b (data_b),
        .pair   (pair),
        .eng_wr (eng_wr),
        .busy   (busy)
    );

endmodule

// File: src/laa_mac_engine.sv
`timescale 1ns/1ps

module laa_mac_engine #(
    parameter int VEC_LEN = 4  // Vector length, 1 to 15
) (
    input  logic                   bus,     // Clock
    input  logic                   reset,
    input  logic                   start,   // One cycle kick from decoder
    input  logic [31:0]            data_a,  // regs[pair.addr_a]
    input  logic [31:0]            data_b,  // regs[pair.addr_b]
    output laa_bus_pkg::laa_pair_t pair,
    output laa_bus_pkg::laa_wr_t   eng_wr,  // Result write
    output logic                   busy
);
    import laa_isa_pkg::*;

    localparam logic [3:0] LAST_IDX = 4'(VEC_LEN - 1);  // Final step index
    localparam logic [4:0] B_BASE   = 5'(VEC_LEN);      // Second vector start

    logic        active;  // Run in progress after the kick cycle
    logic [3:0]  cnt;     // Next step index
    logic [3:0]  idx;     // Step index this cycle
    logic        step;    // A pair is consumed this cycle
    logic        last;
    logic [31:0] prod;    // Low product word
    logic [31:0] acc;     // Running sum
    logic [31:0] sum;

    ////////////////////////////////////////////////////////////
    // Step control
    ////////////////////////////////////////////////////////////

    assign step = start | active;
    assign idx  = start ? 4'd0 : cnt;  // Kick cycle handles pair 0
    assign last = (idx == LAST_IDX);
    assign busy = step;                // High for VEC_LEN cycles

    always_ff @(posedge bus) begin
        if (reset) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (step) begin
            if (last) begin
                active <= 1'b0;  // Done, result goes out this cycle
                cnt    <= '0;
            end else begin
                active <= 1'b1;
                cnt    <= idx + 4'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    assign pair.addr_a = {1'b0, idx};           // Registers 0 .. VEC_LEN-1
    assign pair.addr_b = B_BASE + {1'b0, idx};  // Registers VEC_LEN .. 2*VEC_LEN-1

    assign prod = data_a * data_b;           // Unsigned, low 32 bits kept
    assign sum  = (start ? 32'd0 : acc) + prod;  // New run drops the old sum

    always_ff @(posedge bus) begin
        if (step) begin
            acc <= sum;
        end
    end

    // Result lands in r31 at the end of the last step
    assign eng_wr.en   = step & last;
    assign eng_wr.addr = LAA_RESULT_REG;
    assign eng_wr.data = sum;

endmodule

// File: src/laa_regfile.sv
`timescale 1ns/1ps

module laa_regfile (
    input  logic                   bus,      // Clock
    input  logic                   reset,
    input  laa_bus_pkg::laa_wr_t   core_wr,  // From decoder
    input  laa_bus_pkg::laa_wr_t   eng_wr,   // From MAC engine
    input  logic                   rd_req,
    input  logic [4:0]             rd_laa,   // LAA register to read
    input  logic [4:0]             rd_core,  // Core register to write back
    input  laa_bus_pkg::laa_pair_t pair,     // Engine operand addresses
    output logic [31:0]            data_a,
    output logic [31:0]            data_b,
    output laa_bus_pkg::laa_resp_t resp      // Core write back
);

    logic [31:0] regs [32];  // Accelerator registers

    ////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////

    // Core and engine never collide, decoder idles while busy
    always_ff @(posedge bus) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (core_wr.en) begin
                regs[core_wr.addr] <= core_wr.data;
            end
            if (eng_wr.en) begin
                regs[eng_wr.addr] <= eng_wr.data;  // Result register only
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Core read, one cycle, old contents at the edge
    always_ff @(posedge bus) begin
        if (reset) begin
            resp <= '0;
        end else begin
            resp.reg_write <= rd_req;  // Pulse follows the request
            resp.rd        <= rd_core;
            resp.data      <= regs[rd_laa];
        end
    end

    // Engine operands, same cycle
    assign data_a = regs[pair.addr_a];
    assign data_b = regs[pair.addr_b];

endmodule

// File: src/laa_decoder.sv
`timescale 1ns/1ps

module laa_decoder (
    input  logic                  bus,       // Clock
    input  logic                  reset,
    input  laa_isa_pkg::laa_ins_u ins,       // Instruction word from core
    input  logic [31:0]           rs1_data,  // Core rs1 contents
    input  logic                  busy,      // Engine running
    output logic [4:0]            rs1_addr,  // Core rs1 select for WRITE
    output laa_bus_pkg::laa_wr_t  core_wr,   // Core side regfile write
    output logic                  rd_req,    // Core side regfile read
    output logic [4:0]            rd_laa,
    output logic [4:0]            rd_core,
    output logic                  start      // One cycle engine kick
);
    import laa_isa_pkg::*;

    laa_op_e op;       // Decoded and accepted operation
    logic    legal;    // Major opcode hit
    logic    exec_go;  // EXEC accepted this cycle

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////

    assign legal = (ins.raw[6:0] == LAA_MAJOR);  // Anything else is a no-op

    always_comb begin
        op = OP_NONE;
        // Nothing is taken while the engine runs
        if (legal && !busy) begin
            case (ins.wr.func)  // Func field sits at the same bits in both formats
                FUNC_READ:  op = OP_READ;
                FUNC_WRITE: op = OP_WRITE;
                FUNC_EXEC:  op = OP_EXEC;
                default:    op = OP_NONE;  // Unknown code dropped
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Register file requests
    ////////////////////////////////////////////////////////////

    always_comb begin
        rs1_addr = '0;
        core_wr  = '0;
        rd_req   = 1'b0;
        rd_laa   = '0;
        rd_core  = '0;

        case (op)
            OP_WRITE: begin
                rs1_addr     = ins.wr.core_reg;  // Core returns rs1_data same cycle
                core_wr.en   = 1'b1;
                core_wr.addr = ins.wr.laa_reg;
                core_wr.data = rs1_data;
            end
            OP_READ: begin
                rd_req  = 1'b1;
                rd_laa  = ins.rd.laa_reg;   // Read view of the word
                rd_core = ins.rd.core_reg;
            end
            default: begin
                // EXEC and NONE leave the regfile alone
                rd_req = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Engine start
    ////////////////////////////////////////////////////////////

    assign exec_go = (op == OP_EXEC);

    // Registered kick, engine sees it the cycle after EXEC
    always_ff @(posedge bus) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= exec_go;  // Busy is up next cycle, so one pulse only
        end
    end

endmodule

// File: src/laa_bus_pkg.sv
package laa_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Register file traffic
    ////////////////////////////////////////////////////////////

    // One write into the LAA register file
    typedef struct packed {
        logic        en;    // Write strobe
        logic [4:0]  addr;  // LAA register index
        logic [31:0] data;
    } laa_wr_t;

    // Engine operand addresses, read back in the same cycle
    typedef struct packed {
        logic [4:0] addr_a;  // First vector element
        logic [4:0] addr_b;  // Second vector element
    } laa_pair_t;

    ////////////////////////////////////////////////////////////
    // Core side
    ////////////////////////////////////////////////////////////

    // Register write back into the core, one cycle pulse
    typedef struct packed {
        logic        reg_write;  // Core regfile write enable
        logic [4:0]  rd;         // Core destination register
        logic [31:0] data;       // LAA register contents
    } laa_resp_t;

endpackage

// File: src/laa_isa_pkg.sv
package laa_isa_pkg;

    ////////////////////////////////////////////////////////////
    // Opcode space and function codes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] LAA_MAJOR = 7'b0001011;  // custom-0 major opcode

    // Function field, bits 11 to 7
    typedef enum logic [4:0] {
        FUNC_READ  = 5'b00001,  // LAA reg to core reg
        FUNC_WRITE = 5'b00010,  // Core reg to LAA reg
        FUNC_EXEC  = 5'b00011   // Start dot product run
    } laa_func_e;

    // Operation after decode, NONE covers anything illegal
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE,
        OP_EXEC
    } laa_op_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [4:0] core_reg;   // Source core register
        logic [4:0] laa_reg;    // Destination LAA register
        logic [9:0] unused;
        laa_func_e  func;
        logic [6:0] major;
    } laa_wr_fmt_t;

    // Same layout with the register fields swapped
    typedef struct packed {
        logic [4:0] laa_reg;    // Source LAA register
        logic [4:0] core_reg;   // Destination core register
        logic [9:0] unused;
        laa_func_e  func;
        logic [6:0] major;
    } laa_rd_fmt_t;

    // One word, two views
    typedef union packed {
        laa_wr_fmt_t wr;
        laa_rd_fmt_t rd;
        logic [31:0] raw;
    } laa_ins_u;

    localparam logic [4:0] LAA_RESULT_REG = 5'd31;  // Dot product lands here

endpackage
